/* compile.f */
+incdir+.
sino_pkg.sv
sinogram_addresser.sv
sinogram_ram.sv
filtered_line_ram.sv
sinogram_fetch_top.sv
sinogram_fetch_asserts.sv
tb_sinogram_fetch.sv

/* filtered_line_ram.sv */
`timescale 1ns/10ps
`include "sino_defs.svh"

module filtered_line_ram
(
    input  logic              clk,
    input  logic              reset_n,
    // host run control
    input  logic              hs_kick,
    input  logic              hs_done,
    // addresser
    input  sino_pkg::angle_t  fr_angle,
    input  logic              fr_next_angle_ack,
    output sino_pkg::s_t      fr_s_val,
    output logic              fr_next_angle,
    // sinogram RAM read data
    input  sino_pkg::sample_t sg_data,
    // processing element
    input  sino_pkg::s_t      pe_s,
    input  logic              pe_line_done,
    output logic              pe_line_valid,
    output sino_pkg::angle_t  pe_angle,
    output sino_pkg::sample_t pe_sample
);

    import sino_pkg::*;

    // fill sequencer states
    localparam logic [1:0] idle_s  = 2'd0;
    localparam logic [1:0] fill_s  = 2'd1;
    localparam logic [1:0] flush_s = 2'd2;
    localparam logic [1:0] swap_s  = 2'd3;

    // two line banks, indexed by bank then s
    sample_t line_mem [0:1][0:`kProjectionLineSize-1];

    logic [1:0] state;
    s_t         s_cnt;

    // write side trails the issued s by the RAM latency
    logic       wr_pending;
    s_t         wr_s;

    // bank currently being filled, the other one drains
    logic       fill_sel;
    logic       drain_sel;

    assign drain_sel = ~fill_sel;
    assign fr_s_val  = s_cnt;

    // swap only once the drain bank has been released
    assign fr_next_angle = (state == swap_s) && !pe_line_valid;

    // fill sequencer
    // s runs 0..15, one cycle for the last write, then the swap
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= idle_s;
            s_cnt <= '0;
        end
        else
        begin
            case (state)
                idle_s:
                begin
                    if (hs_kick)
                    begin
                        state <= fill_s;
                        s_cnt <= '0;
                    end
                end
                fill_s:
                begin
                    if (s_cnt == s_t'(`kProjectionLineSize - 1))
                        state <= flush_s;
                    else
                        s_cnt <= s_cnt + 1'b1;
                end
                flush_s:
                begin
                    // last sample lands in the bank this cycle
                    state <= swap_s;
                end
                swap_s:
                begin
                    // hold here while the PE still owns the drain bank
                    if (fr_next_angle)
                    begin
                        s_cnt <= '0;
                        if (fr_next_angle_ack && !hs_done)
                            state <= fill_s;
                        else
                            state <= idle_s;
                    end
                end
                default:
                begin
                    state <= idle_s;
                end
            endcase
        end
    end

    // delay line for the write index
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_pending <= 1'b0;
        end
        else
        begin
            wr_pending <= (state == fill_s);
        end
    end

    always_ff @(posedge clk)
    begin
        wr_s <= s_cnt;
    end

    // fill bank write
    // fill_sel is steady here since the swap comes after the last write
    always_ff @(posedge clk)
    begin
        if (wr_pending)
        begin
            line_mem[fill_sel][wr_s] <= sg_data;
        end
    end

    // bank select and drain ownership
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_sel      <= 1'b0;
            pe_line_valid <= 1'b0;
        end
        else if (fr_next_angle)
        begin
            fill_sel      <= ~fill_sel;
            pe_line_valid <= 1'b1;
        end
        else if (pe_line_done)
        begin
            pe_line_valid <= 1'b0;
        end
    end

    // angle of the line just handed over
    // fr_angle still shows the old value during the swap cycle
    always_ff @(posedge clk)
    begin
        if (fr_next_angle)
        begin
            pe_angle <= fr_angle;
        end
    end

    // drain read, one cycle latency
    always_ff @(posedge clk)
    begin
        pe_sample <= line_mem[drain_sel][pe_s];
    end

endmodule

/* sino_defs.svh */
`ifndef SINO_DEFS_SVH
`define SINO_DEFS_SVH

// one sinogram sample
`define kSampleLength 12

// position index along a projection line
`define kSLength 4
// samples per projection line
`define kProjectionLineSize 16

// angle in whole degrees
`define kAngleLength 8
// degrees between consecutive lines
`define kAngleStep 20
// 180 / step, lines per half turn
`define kNoOfAngles 9

// flat word address into the sinogram store
`define kSinogramAddressLength 8
// angles times line size
`define kSinogramDepth 144

`endif

/* sino_pkg.sv */
`include "sino_defs.svh"

package sino_pkg;

    // raw sinogram sample
    typedef logic [`kSampleLength-1:0] sample_t;

    // s index, position within one projection line
    typedef logic [`kSLength-1:0] s_t;

    // projection angle in degrees, 0 .. 160
    typedef logic [`kAngleLength-1:0] angle_t;

    // word address into the sinogram RAM
    typedef logic [`kSinogramAddressLength-1:0] sg_addr_t;

endpackage

/* sinogram_addresser.sv */
`timescale 1ns/10ps
`include "sino_defs.svh"

module sinogram_addresser
(
    input  logic              clk,
    input  logic              reset_n,
    // host
    input  logic              hs_kick,
    output logic              hs_done,
    // line RAM
    input  sino_pkg::s_t      fr_s_val,
    input  logic              fr_next_angle,
    output sino_pkg::angle_t  fr_angle,
    output logic              fr_has_next_angle,
    output logic              fr_next_angle_ack,
    // sinogram RAM read address
    output sino_pkg::sg_addr_t sg_addr
);

    import sino_pkg::*;

    // two-state control
    localparam logic ready_s = 1'b0;
    localparam logic work_s  = 1'b1;

    logic     state;
    sg_addr_t sg_base_addr;

    // last line of the run is the one at 160 degrees
    assign fr_has_next_angle = (fr_angle < angle_t'(`kAngleStep * (`kNoOfAngles - 1)));

    // done on the swap of the final line, same cycle as the pulse
    assign hs_done = fr_next_angle && !fr_has_next_angle;

    // tells the line RAM to keep filling after this swap
    assign fr_next_angle_ack = (state == work_s) && fr_has_next_angle && fr_next_angle;

    // line base plus the position the fill sequencer asks for
    assign sg_addr = sg_base_addr + sg_addr_t'(fr_s_val);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= ready_s;
        end
        else if (state == ready_s)
        begin
            // kick only counts while idle
            if (hs_kick)
                state <= work_s;
        end
        else if (hs_done)
        begin
            state <= ready_s;
        end
    end

    // angle iterator and base address move together
    always_ff @(posedge clk)
    begin
        if (!reset_n || state == ready_s)
        begin
            fr_angle     <= '0;
            sg_base_addr <= '0;
        end
        else if (fr_next_angle && fr_has_next_angle)
        begin
            fr_angle     <= fr_angle + angle_t'(`kAngleStep);
            // one whole projection line further on
            sg_base_addr <= sg_base_addr + sg_addr_t'(`kProjectionLineSize);
        end
    end

endmodule

/* sinogram_fetch_asserts.sv */
`timescale 1ns/10ps

module sinogram_fetch_asserts
(
    input logic             clk,
    input logic             reset_n,
    input logic             hs_done,
    input logic             fr_next_angle,
    input logic             pe_line_valid,
    input sino_pkg::angle_t pe_angle
);

    // run end is a single pulse
    done_single_pulse: assert property (
        @(posedge clk) disable iff (!reset_n)
        hs_done |=> !hs_done
    ) else $error("hs_done high on two consecutive cycles");

    // angle of a held line never moves
    pe_angle_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        pe_line_valid ##1 pe_line_valid |-> $stable(pe_angle)
    ) else $error("pe_angle changed while pe_line_valid was high");

    // swap only into a free drain bank, which then holds the new line
    swap_needs_free_bank: assert property (
        @(posedge clk) disable iff (!reset_n)
        fr_next_angle |-> !pe_line_valid ##1 pe_line_valid
    ) else $error("fr_next_angle pulsed into a held drain bank or no line followed");

endmodule

// fr_next_angle is internal to the top level
bind sinogram_fetch_top sinogram_fetch_asserts i_asserts
(
    .clk           (clk),
    .reset_n       (reset_n),
    .hs_done       (hs_done),
    .fr_next_angle (fr_next_angle),
    .pe_line_valid (pe_line_valid),
    .pe_angle      (pe_angle)
);

/* sinogram_fetch_top.sv */
`timescale 1ns/10ps

module sinogram_fetch_top
(
    input  logic               clk,
    input  logic               reset_n,
    // host load port
    input  logic               hs_wr_en,
    input  sino_pkg::sg_addr_t hs_wr_addr,
    input  sino_pkg::sample_t  hs_wr_data,
    // host run control
    input  logic               hs_kick,
    output logic               hs_done,
    // processing element
    input  sino_pkg::s_t       pe_s,
    input  logic               pe_line_done,
    output logic               pe_line_valid,
    output sino_pkg::angle_t   pe_angle,
    output sino_pkg::sample_t  pe_sample
);

    import sino_pkg::*;

    // addresser <-> line RAM
    s_t       fr_s_val;
    logic     fr_next_angle;
    angle_t   fr_angle;
    logic     fr_next_angle_ack;

    // sinogram RAM read path
    sg_addr_t sg_addr;
    sample_t  sg_data;

    // has-next flag is only used inside the addresser
    sinogram_addresser i_addresser
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_kick           (hs_kick),
        .hs_done           (hs_done),
        .fr_s_val          (fr_s_val),
        .fr_next_angle     (fr_next_angle),
        .fr_angle          (fr_angle),
        .fr_has_next_angle (),
        .fr_next_angle_ack (fr_next_angle_ack),
        .sg_addr           (sg_addr)
    );

    // written by the host and read by the addresser
    sinogram_ram i_sinogram_ram
    (
        .clk     (clk),
        .wr_en   (hs_wr_en),
        .wr_addr (hs_wr_addr),
        .wr_data (hs_wr_data),
        .rd_addr (sg_addr),
        .rd_data (sg_data)
    );

    filtered_line_ram i_line_ram
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_kick           (hs_kick),
        .hs_done           (hs_done),
        .fr_angle          (fr_angle),
        .fr_next_angle_ack (fr_next_angle_ack),
        .fr_s_val          (fr_s_val),
        .fr_next_angle     (fr_next_angle),
        .sg_data           (sg_data),
        .pe_s              (pe_s),
        .pe_line_done      (pe_line_done),
        .pe_line_valid     (pe_line_valid),
        .pe_angle          (pe_angle),
        .pe_sample         (pe_sample)
    );

endmodule

/* sinogram_ram.sv */
`timescale 1ns/10ps
`include "sino_defs.svh"

module sinogram_ram
(
    input  logic               clk,
    // host write port
    input  logic               wr_en,
    input  sino_pkg::sg_addr_t wr_addr,
    input  sino_pkg::sample_t  wr_data,
    // addresser read port
    input  sino_pkg::sg_addr_t rd_addr,
    output sino_pkg::sample_t  rd_data
);

    import sino_pkg::*;

    // one line per angle, lines stored back to back
    sample_t mem [0:`kSinogramDepth-1];

    // host load, one word per enabled cycle
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read
    // data is back one cycle after the address
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* tb_sinogram_fetch.sv */
`timescale 1ns/10ps
`include "sino_defs.svh"

module tb_sinogram_fetch;

    import sino_pkg::*;

    localparam int num_rows  = 4;
    localparam int fill_ramp = 0;
    localparam int fill_lfsr = 1;

    // test table with one full run per row
    int row_fill  [0:num_rows-1] = '{fill_ramp, fill_lfsr, fill_lfsr, fill_ramp};
    // PE hold in cycles before the line is released
    int row_hold  [0:num_rows-1] = '{0, 3, 40, 0};
    int row_lines [0:num_rows-1] = '{`kNoOfAngles, `kNoOfAngles, `kNoOfAngles, `kNoOfAngles};

    logic        clk;
    logic        reset_n;
    logic        hs_wr_en;
    sg_addr_t    hs_wr_addr;
    sample_t     hs_wr_data;
    logic        hs_kick;
    logic        hs_done;
    s_t          pe_s;
    logic        pe_line_done;
    logic        pe_line_valid;
    angle_t      pe_angle;
    sample_t     pe_sample;

    // reference copy of what the host wrote
    sample_t     sino_model [0:`kSinogramDepth-1];
    logic [15:0] lfsr;
    int          errors;
    int          failed_rows;
    int          done_count;
    int          lines_seen;
    bit          valid_seen;
    bit          kicked;

    sinogram_fetch_top i_dut
    (
        .clk           (clk),
        .reset_n       (reset_n),
        .hs_wr_en      (hs_wr_en),
        .hs_wr_addr    (hs_wr_addr),
        .hs_wr_data    (hs_wr_data),
        .hs_kick       (hs_kick),
        .hs_done       (hs_done),
        .pe_s          (pe_s),
        .pe_line_done  (pe_line_done),
        .pe_line_valid (pe_line_valid),
        .pe_angle      (pe_angle),
        .pe_sample     (pe_sample)
    );

    // 4 ns period
    always
    begin
        #2 clk = ~clk;
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic load_sinogram(input int row, input int fill);
        sample_t word;
        for (int addr = 0; addr < `kSinogramDepth; addr++)
        begin
            if (fill == fill_lfsr)
            begin
                // one step per bit taken
                for (int b = 0; b < `kSampleLength; b++)
                begin
                    lfsr = lfsr_step(lfsr);
                    word = {word[`kSampleLength-2:0], lfsr[0]};
                end
            end
            else
            begin
                // ramp offset per row so reruns see new data
                word = sample_t'(addr + row * 'h155);
            end
            @(posedge clk);
            #1;
            hs_wr_en         = 1'b1;
            hs_wr_addr       = sg_addr_t'(addr);
            hs_wr_data       = word;
            sino_model[addr] = word;
        end
        @(posedge clk);
        #1;
        hs_wr_en = 1'b0;
    endtask

    task automatic kick_run();
        @(posedge clk);
        #1;
        hs_kick = 1'b1;
        kicked  = 1'b1;
        @(posedge clk);
        #1;
        hs_kick = 1'b0;
    endtask

    // PE model for one line
    task automatic drain_line(input int line, input int hold, input int lines);
        angle_t  expected_angle;
        sample_t expected;
        expected_angle = angle_t'(line * `kAngleStep);
        do
            @(negedge clk);
        while (!pe_line_valid);
        if (pe_angle !== expected_angle)
        begin
            $display("Fail pe_angle line %0d: got %h expected %h", line, pe_angle, expected_angle);
            errors++;
        end
        // done belongs to the swap of the last line only
        if (line < lines - 1 && done_count != 0)
        begin
            $display("hs_done came before line %0d was valid", line);
            errors++;
        end
        if (line == lines - 1 && done_count != 1)
        begin
            $display("hs_done missing at the swap of the last line");
            errors++;
        end
        // sample for s shows one cycle after s is driven
        for (int i = 0; i <= `kProjectionLineSize; i++)
        begin
            @(posedge clk);
            #1;
            if (i < `kProjectionLineSize)
                pe_s = s_t'(i);
            @(negedge clk);
            if (i > 0)
            begin
                expected = sino_model[line * `kProjectionLineSize + i - 1];
                if (pe_sample !== expected)
                begin
                    $display("Fail pe_sample line %0d s %0d: got %h expected %h",
                             line, i - 1, pe_sample, expected);
                    errors++;
                end
            end
        end
        repeat (hold) @(posedge clk);
        @(posedge clk);
        #1;
        pe_line_done = 1'b1;
        @(posedge clk);
        #1;
        pe_line_done = 1'b0;
    endtask

    // counts done pulses and line hand-overs
    // also watches the outputs before the first kick
    always @(negedge clk)
    begin
        if (reset_n && hs_done)
            done_count++;
        // a new line shows as a rise of pe_line_valid
        if (reset_n && pe_line_valid && !valid_seen)
            lines_seen++;
        valid_seen = pe_line_valid;
        if (reset_n && !kicked && (hs_done || pe_line_valid))
        begin
            $display("hs_done or pe_line_valid went high before the first kick");
            errors++;
        end
    end

    initial
    begin : watchdog
        longint limit_cycles;
        // reset plus per row a RAM load and every line with its hold and slack
        limit_cycles = 16;
        for (int r = 0; r < num_rows; r++)
            limit_cycles += `kSinogramDepth + 64 + row_lines[r] * (18 + row_hold[r] + 20);
        #(limit_cycles * 4);
        $display("watchdog expired after %0d ns, the run did not finish", limit_cycles * 4);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin : main_seq
        int row_start;
        bit extra_line;
        clk          = 1'b0;
        reset_n      = 1'b0;
        hs_wr_en     = 1'b0;
        hs_wr_addr   = '0;
        hs_wr_data   = '0;
        hs_kick      = 1'b0;
        pe_s         = '0;
        pe_line_done = 1'b0;
        lfsr         = 16'd24489;
        errors       = 0;
        failed_rows  = 0;
        done_count   = 0;
        lines_seen   = 0;
        kicked       = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        reset_n = 1'b1;
        // idle stretch while the monitor watches the outputs stay low
        repeat (8) @(posedge clk);

        for (int row = 0; row < num_rows; row++)
        begin
            row_start  = errors;
            extra_line = 1'b0;
            load_sinogram(row, row_fill[row]);
            done_count = 0;
            lines_seen = 0;
            kick_run();
            for (int line = 0; line < row_lines[row]; line++)
                drain_line(line, row_hold[row], row_lines[row]);
            while (done_count == 0)
                @(negedge clk);
            // no new line may show up for longer than one fill
            repeat (2 * `kProjectionLineSize)
            begin
                @(negedge clk);
                if (pe_line_valid)
                    extra_line = 1'b1;
            end
            if (extra_line)
            begin
                $display("a line appeared after hs_done in row %0d", row);
                errors++;
            end
            if (done_count != 1)
            begin
                $display("Fail hs_done count: got %h expected %h", done_count, 1);
                errors++;
            end
            if (lines_seen != row_lines[row])
            begin
                $display("Fail line count: got %h expected %h", lines_seen, row_lines[row]);
                errors++;
            end
            if (errors != row_start)
                failed_rows++;
            $display("row %0d fill %s hold %0d: %0d lines, %0d errors", row,
                     (row_fill[row] == fill_lfsr) ? "lfsr" : "ramp",
                     row_hold[row], lines_seen, errors - row_start);
        end

        $display("rows %0d, failing rows %0d, errors %0d", num_rows, failed_rows, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
